//--- tb.f
hdl/packetmem_pkg.sv
hdl/packet_ram.sv
hdl/p3_ctrl.sv
hdl/port_mux.sv
hdl/read_size_adapter.sv
hdl/packetmem.sv
bench/packetmem_sva.sv
bench/tb_packetmem.sv

//--- bench/tb_packetmem.sv
module tb_packetmem import packetmem_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_PKT      = 12;	// Packets through the whole pipeline
	localparam int WAIT_LIMIT = 4000;	// Cycles before a wait gives up

	logic clk, rst;
	word_addr_t snooper_wr_addr, forwarder_rd_addr;
	word_t      snooper_wr_data, cpu_rd_data, forwarder_rd_data;
	logic       snooper_wr_en, snooper_done, ready_for_snooper;
	byte_addr_t cpu_byte_rd_addr;
	xfer_sz_t   transfer_sz;
	logic       cpu_rd_en, cpu_acc, cpu_rej, ready_for_cpu;
	logic       forwarder_rd_en, forwarder_done, ready_for_forwarder;
	plen_t      len_to_cpu, len_to_forwarder;

	word_t       pkt_mem [N_PKT][64];	// Model copy of every packet
	int          pkt_len [N_PKT];
	int          cpu_q [$];	// Snooped, CPU has not taken them yet
	int          fwd_q [$];	// Accepted, forwarder not finished
	bit          saw_wait, saw_block, cpu_finished;
	logic [31:0] rng = 32'd64;

	packetmem u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		rng = xorshift(rng);
		return rng % n;
	endfunction

	// Little-endian bytes of the model packet, zeros above
	function automatic word_t expected_bytes(input int id, input int ba, input int nb);
		word_t r;
		int    k;
		r = '0;
		for (k = 0; k < nb; k++)
			r[8 * k +: 8] = pkt_mem[id][(ba + k) / 4][8 * ((ba + k) % 4) +: 8];
		return r;
	endfunction

	function automatic logic ready_level(input int agent);
		case (agent)
			0:       return ready_for_snooper;
			1:       return ready_for_cpu;
			default: return ready_for_forwarder;
		endcase
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_len(input plen_t got, input plen_t exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_sel(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("Mismatch at %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// Any failed controller assertion ends the run at once
	always @(posedge clk) begin
		if (u_dut.u_ctrl.u_sva.fails != 0)
			stop_with_failure("An assertion on the buffer controller failed");
	end

	// Returns at a falling edge with the agent's ready high
	task automatic wait_ready(input int agent, input string who);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!ready_level(agent)) begin
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_with_failure({"Timeout: ", who, " never became ready"});
			@(negedge clk);
		end
	endtask

	task automatic wait_for_work();
		int cycles;
		cycles = 0;
		while (fwd_q.size() == 0 && !cpu_finished) begin
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_with_failure("Timeout: forwarder never got an accepted packet");
			@(negedge clk);
		end
	endtask

	task automatic snoop_packet(input int id);
		int n;
		n = rand_below(64) + 1;
		pkt_len[id] = n;
		wait_ready(0, "snooper");
		for (int w = 0; w < n; w++) begin
			@(posedge clk);
			pkt_mem[id][w] = xorshift(rng);
			rng = pkt_mem[id][w];
			snooper_wr_en   <= 1'b1;
			snooper_wr_addr <= word_addr_t'(w);
			snooper_wr_data <= pkt_mem[id][w];
		end
		@(posedge clk);
		snooper_wr_en <= 1'b0;
		snooper_done  <= 1'b1;
		cpu_q.push_back(id);
		@(posedge clk);
		snooper_done <= 1'b0;
		@(negedge clk);	// Ownership has moved by now
		if (id == 0) begin	// CPU slot empty, handover in one cycle
			check_sel(ready_for_cpu, 1'b1, "ready_for_cpu after first snooper_done");
			check_len(len_to_cpu, plen_t'(n), "len_to_cpu after first snooper_done");
		end
		if (!ready_for_snooper && !ready_for_cpu)
			saw_block = 1'b1;	// All three buffers taken
	endtask

	task automatic inspect_packet();
		int       id, nb, ba;
		xfer_sz_t sz;
		wait_ready(1, "CPU");
		id = cpu_q.pop_front();
		check_len(len_to_cpu, plen_t'(pkt_len[id]), "len_to_cpu");
		repeat (rand_below(6) + 1) begin
			sz = xfer_sz_t'(rand_below(4));
			nb = (sz == 2'd0) ? 1 : (sz == 2'd1) ? 2 : 4;
			ba = rand_below(pkt_len[id] * 4 - nb + 1);	// Stay inside the packet
			@(posedge clk);
			cpu_rd_en        <= 1'b1;
			cpu_byte_rd_addr <= byte_addr_t'(ba);
			transfer_sz      <= sz;
			@(posedge clk);
			cpu_rd_en <= 1'b0;
			@(negedge clk);
			check_word(cpu_rd_data, expected_bytes(id, ba, nb), "cpu_rd_data");
		end
		@(posedge clk);
		if (rand_below(4) == 0) begin
			cpu_rej <= 1'b1;
			@(posedge clk);
			cpu_rej <= 1'b0;
		end else begin
			cpu_acc <= 1'b1;
			fwd_q.push_back(id);
			@(posedge clk);
			cpu_acc <= 1'b0;
			@(negedge clk);
			if (fwd_q.size() > 1) begin	// Forwarder still busy, accept must wait
				check_sel(ready_for_cpu, 1'b0, "ready_for_cpu with forwarder full");
				saw_wait = 1'b1;
			end
		end
	endtask

	task automatic forward_packet();
		int id;
		repeat (rand_below(200) + 100) @(posedge clk);	// Slow forwarder
		wait_ready(2, "forwarder");
		id = fwd_q[0];
		check_len(len_to_forwarder, plen_t'(pkt_len[id]), "len_to_forwarder");
		for (int w = 0; w < pkt_len[id]; w++) begin
			@(posedge clk);
			forwarder_rd_en   <= 1'b1;
			forwarder_rd_addr <= word_addr_t'(w);
			@(posedge clk);
			forwarder_rd_en <= 1'b0;
			@(negedge clk);
			check_word(forwarder_rd_data, pkt_mem[id][w], "forwarder_rd_data");
		end
		@(posedge clk);
		forwarder_done <= 1'b1;
		@(posedge clk);
		forwarder_done <= 1'b0;
		void'(fwd_q.pop_front());	// Controller saw done on this edge
	endtask

	initial begin
		rst = 1'b1;
		snooper_wr_addr = '0;
		snooper_wr_data = '0;
		snooper_wr_en = 1'b0;
		snooper_done = 1'b0;
		cpu_byte_rd_addr = '0;
		transfer_sz = '0;
		cpu_rd_en = 1'b0;
		cpu_acc = 1'b0;
		cpu_rej = 1'b0;
		forwarder_rd_addr = '0;
		forwarder_rd_en = 1'b0;
		forwarder_done = 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_sel(ready_for_snooper, 1'b1, "ready_for_snooper after reset");
		check_sel(ready_for_cpu, 1'b0, "ready_for_cpu after reset");
		check_sel(ready_for_forwarder, 1'b0, "ready_for_forwarder after reset");
		check_len(len_to_cpu, '0, "len_to_cpu after reset");
		check_len(len_to_forwarder, '0, "len_to_forwarder after reset");
		fork
			for (int p = 0; p < N_PKT; p++)
				snoop_packet(p);
			begin
				for (int p = 0; p < N_PKT; p++)
					inspect_packet();
				cpu_finished = 1'b1;
			end
			begin
				wait_for_work();
				while (fwd_q.size() != 0) begin
					forward_packet();
					wait_for_work();
				end
			end
		join
		@(negedge clk);
		if (u_dut.u_ctrl.u_sva.fails != 0)
			stop_with_failure("An assertion on the buffer controller failed");
		else if (!saw_wait || !saw_block)
			stop_with_failure("The slow forwarder never held back both the CPU and the snooper");
		else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

//--- bench/packetmem_sva.sv
module packetmem_sva import packetmem_pkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     snooper_done,
	input logic     cpu_acc,
	input logic     cpu_rej,
	input logic     forwarder_done,
	input buf_sel_t sn_sel,
	input buf_sel_t cpu_sel,
	input buf_sel_t fwd_sel,
	input logic     len_rst [NUM_BUFS]
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fails = 0;	// Assertion failures so far
	logic clean_q [NUM_BUFS];	// Length cleared since the snooper last held it

	always_ff @(posedge clk) begin
		for (int b = 0; b < NUM_BUFS; b++) begin
			if (len_rst[b])
				clean_q[b] <= 1'b1;
			else if (sn_sel == buf_sel_t'(b + 1))
				clean_q[b] <= 1'b0;	// Snooper may write from here on
		end
	end

	a_sn_pulse: assert property (@(posedge clk) disable iff (rst)
		snooper_done |=> !snooper_done)
	else begin
		$error("snooper_done longer than one cycle");
		fails++;
	end
	a_acc_pulse: assert property (@(posedge clk) disable iff (rst)
		cpu_acc |=> !cpu_acc)
	else begin
		$error("cpu_acc longer than one cycle");
		fails++;
	end
	a_rej_pulse: assert property (@(posedge clk) disable iff (rst)
		cpu_rej |=> !cpu_rej)
	else begin
		$error("cpu_rej longer than one cycle");
		fails++;
	end
	a_fwd_pulse: assert property (@(posedge clk) disable iff (rst)
		forwarder_done |=> !forwarder_done)
	else begin
		$error("forwarder_done longer than one cycle");
		fails++;
	end
	// One owner per buffer
	a_sel_unique: assert property (@(posedge clk) disable iff (rst)
		(sn_sel == 0 || (sn_sel != cpu_sel && sn_sel != fwd_sel))
		&& (cpu_sel == 0 || cpu_sel != fwd_sel))
	else begin
		$error("two agents hold the same buffer");
		fails++;
	end
	// Fresh grant to the snooper only on a buffer with zero length
	a_grant_clean: assert property (@(posedge clk) disable iff (rst)
		(sn_sel != 0 && sn_sel != $past(sn_sel)) |-> clean_q[sn_sel - 1])
	else begin
		$error("snooper granted a buffer with a stale length");
		fails++;
	end

endmodule

bind p3_ctrl packetmem_sva u_sva (
	.clk, .rst, .snooper_done, .cpu_acc, .cpu_rej, .forwarder_done,
	.sn_sel, .cpu_sel, .fwd_sel, .len_rst
);

//--- hdl/packetmem.sv
module packetmem import packetmem_pkg::*; (
	input  logic       clk,
	input  logic       rst,

	// Snooper
	input  word_addr_t snooper_wr_addr,
	input  word_t      snooper_wr_data,
	input  logic       snooper_wr_en,
	input  logic       snooper_done,	// One-cycle pulse
	output logic       ready_for_snooper,

	// CPU
	input  byte_addr_t cpu_byte_rd_addr,
	input  xfer_sz_t   transfer_sz,
	input  logic       cpu_rd_en,
	input  logic       cpu_acc,	// Pulses, never together
	input  logic       cpu_rej,
	output word_t      cpu_rd_data,
	output logic       ready_for_cpu,
	output plen_t      len_to_cpu,

	// Forwarder
	input  word_addr_t forwarder_rd_addr,
	input  logic       forwarder_rd_en,
	input  logic       forwarder_done,	// One-cycle pulse
	output word_t      forwarder_rd_data,
	output logic       ready_for_forwarder,
	output plen_t      len_to_forwarder
);

	buf_sel_t sn_sel, cpu_sel, fwd_sel;
	logic     len_rst [NUM_BUFS];
	mem_req_t sn_req, cpu_req, fwd_req;
	mem_rsp_t cpu_rsp, fwd_rsp;
	mem_req_t buf_req [NUM_BUFS];
	mem_rsp_t buf_rsp [NUM_BUFS];

	// Agent ports packed into requests
	assign sn_req  = '{addr: snooper_wr_addr, wdata: snooper_wr_data,
		we: snooper_wr_en, re: 1'b0};
	assign fwd_req = '{addr: forwarder_rd_addr, wdata: '0, we: 1'b0, re: forwarder_rd_en};

	assign len_to_cpu        = cpu_rsp.len;
	assign forwarder_rd_data = fwd_rsp.rdata_lo;	// High word unused here
	assign len_to_forwarder  = fwd_rsp.len;

	p3_ctrl u_ctrl (
		.clk, .rst, .snooper_done, .cpu_acc, .cpu_rej, .forwarder_done,
		.sn_sel, .cpu_sel, .fwd_sel,
		.ready_for_snooper, .ready_for_cpu, .ready_for_forwarder, .len_rst
	);

	read_size_adapter u_adapter (
		.clk, .byte_rd_addr(cpu_byte_rd_addr), .transfer_sz, .rd_en(cpu_rd_en),
		.req(cpu_req), .rsp(cpu_rsp), .rd_data(cpu_rd_data)
	);

	port_mux u_mux (
		.sn_req, .cpu_req, .fwd_req, .sn_sel, .cpu_sel, .fwd_sel,
		.buf_rsp, .buf_req, .cpu_rsp, .fwd_rsp
	);

	// The three rotating buffers
	packet_ram ping (.clk, .req(buf_req[0]), .len_rst(len_rst[0]), .rsp(buf_rsp[0]));
	packet_ram pang (.clk, .req(buf_req[1]), .len_rst(len_rst[1]), .rsp(buf_rsp[1]));
	packet_ram pung (.clk, .req(buf_req[2]), .len_rst(len_rst[2]), .rsp(buf_rsp[2]));

endmodule

//--- hdl/read_size_adapter.sv
module read_size_adapter import packetmem_pkg::*; (
	input  logic       clk,
	input  byte_addr_t byte_rd_addr,
	input  xfer_sz_t   transfer_sz,
	input  logic       rd_en,
	output mem_req_t   req,
	input  mem_rsp_t   rsp,
	output word_t      rd_data	// Zero-padded on the left
);

	logic [1:0]          off_q;	// Byte offset inside the low word
	xfer_sz_t            sz_q;
	logic [2*WORD_W-1:0] pair;	// Little-endian word pair
	logic [2*WORD_W-1:0] shifted;

	// Word holding the first byte, the RAM adds the next one
	assign req.addr  = byte_rd_addr[BYTE_ADDR_W-1:2];
	assign req.wdata = '0;
	assign req.we    = 1'b0;
	assign req.re    = rd_en;

	// Offset and size line up with the data a cycle later
	always_ff @(posedge clk) begin
		if (rd_en) begin
			off_q <= byte_rd_addr[1:0];
			sz_q  <= transfer_sz;
		end
	end

	assign pair    = {rsp.rdata_hi, rsp.rdata_lo};
	assign shifted = pair >> {off_q, 3'b000};	// Offset in bytes to bits

	always_comb begin
		case (sz_q)
			2'd0:    rd_data = {24'd0, shifted[7:0]};
			2'd1:    rd_data = {16'd0, shifted[15:0]};
			default: rd_data = shifted[WORD_W-1:0];	// Full word
		endcase
	end

endmodule

//--- hdl/port_mux.sv
module port_mux import packetmem_pkg::*; (
	input  mem_req_t sn_req,
	input  mem_req_t cpu_req,
	input  mem_req_t fwd_req,
	input  buf_sel_t sn_sel,
	input  buf_sel_t cpu_sel,
	input  buf_sel_t fwd_sel,
	input  mem_rsp_t buf_rsp [NUM_BUFS],
	output mem_req_t buf_req [NUM_BUFS],
	output mem_rsp_t cpu_rsp,
	output mem_rsp_t fwd_rsp
);

	mem_req_t cpu_rd;	// CPU request with writes stripped

	always_comb begin
		cpu_rd    = cpu_req;
		cpu_rd.we = 1'b0;	// CPU only ever reads
	end

	// Request side, each buffer finds its owner
	always_comb begin
		for (int b = 0; b < NUM_BUFS; b++) begin
			// The controller never gives one buffer to two agents
			if (sn_sel == buf_sel_t'(b + 1))
				buf_req[b] = sn_req;
			else if (cpu_sel == buf_sel_t'(b + 1))
				buf_req[b] = cpu_rd;
			else if (fwd_sel == buf_sel_t'(b + 1))
				buf_req[b] = fwd_req;
			else
				buf_req[b] = '0;	// Idle buffer, no access
		end
	end

	// Response side, zero when the agent holds nothing
	always_comb begin
		cpu_rsp = '0;
		fwd_rsp = '0;
		for (int b = 0; b < NUM_BUFS; b++) begin
			if (cpu_sel == buf_sel_t'(b + 1))
				cpu_rsp = buf_rsp[b];
			if (fwd_sel == buf_sel_t'(b + 1))
				fwd_rsp = buf_rsp[b];
		end
	end

	// Snooper never reads back, so its response is not routed

endmodule

//--- hdl/p3_ctrl.sv
module p3_ctrl import packetmem_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     snooper_done,	// One-cycle pulses from the agents
	input  logic     cpu_acc,
	input  logic     cpu_rej,
	input  logic     forwarder_done,
	output buf_sel_t sn_sel,
	output buf_sel_t cpu_sel,
	output buf_sel_t fwd_sel,
	output logic     ready_for_snooper,
	output logic     ready_for_cpu,
	output logic     ready_for_forwarder,
	output logic     len_rst [NUM_BUFS]
);

	ctrl_state_t sn_st, cpu_st, fwd_st;	// Slot states
	ctrl_state_t sn_st_d, cpu_st_d, fwd_st_d;
	buf_sel_t    sn_sel_d, cpu_sel_d, fwd_sel_d;
	logic        fwd_free;	// Forwarder gives its buffer back
	logic        cpu_drop;	// CPU rejects its buffer

	always_comb begin
		sn_st_d   = sn_st;
		cpu_st_d  = cpu_st;
		fwd_st_d  = fwd_st;
		sn_sel_d  = sn_sel;
		cpu_sel_d = cpu_sel;
		fwd_sel_d = fwd_sel;
		fwd_free  = forwarder_done && fwd_st == SLOT_BUSY;
		cpu_drop  = cpu_rej && cpu_st == SLOT_BUSY;

		// Forwarder finished, slot opens up
		if (fwd_free) begin
			fwd_st_d  = SLOT_EMPTY;
			fwd_sel_d = '0;
		end

		// Accept now, or one left pending from before
		if ((cpu_acc && cpu_st == SLOT_BUSY) || cpu_st == SLOT_WAIT) begin
			if (fwd_st_d == SLOT_EMPTY) begin
				fwd_st_d  = SLOT_BUSY;
				fwd_sel_d = cpu_sel;
				cpu_st_d  = SLOT_EMPTY;
				cpu_sel_d = '0;
			end else begin
				cpu_st_d = SLOT_WAIT;	// Holds the buffer, ready drops
			end
		end

		// Reject goes straight back to the free pool
		if (cpu_drop) begin
			cpu_st_d  = SLOT_EMPTY;
			cpu_sel_d = '0;
		end

		// Finished packet moves on to the CPU when it can
		if ((snooper_done && sn_st == SLOT_BUSY) || sn_st == SLOT_DONE) begin
			if (cpu_st_d == SLOT_EMPTY) begin
				cpu_st_d  = SLOT_BUSY;
				cpu_sel_d = sn_sel;
				sn_st_d   = SLOT_EMPTY;
				sn_sel_d  = '0;
			end else begin
				sn_st_d = SLOT_DONE;
			end
		end

		// Snooper grabs the lowest free buffer, counting down so 1 wins
		if (sn_st_d == SLOT_EMPTY) begin
			for (int b = NUM_BUFS; b >= 1; b--) begin
				if (cpu_sel_d != buf_sel_t'(b) && fwd_sel_d != buf_sel_t'(b)) begin
					sn_sel_d = buf_sel_t'(b);
					sn_st_d  = SLOT_BUSY;
				end
			end
		end

		// Length clears land on the same edge as the ownership change
		for (int b = 0; b < NUM_BUFS; b++) begin
			len_rst[b] = rst	// Every buffer starts empty
				|| (fwd_free && fwd_sel == buf_sel_t'(b + 1))
				|| (cpu_drop && cpu_sel == buf_sel_t'(b + 1));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sn_sel  <= buf_sel_t'(1);	// Ping goes to the snooper
			sn_st   <= SLOT_BUSY;
			cpu_sel <= '0;
			cpu_st  <= SLOT_EMPTY;
			fwd_sel <= '0;
			fwd_st  <= SLOT_EMPTY;
		end else begin
			sn_sel  <= sn_sel_d;
			sn_st   <= sn_st_d;
			cpu_sel <= cpu_sel_d;
			cpu_st  <= cpu_st_d;
			fwd_sel <= fwd_sel_d;
			fwd_st  <= fwd_st_d;
		end
	end

	// An agent may act only while it owns its buffer outright
	assign ready_for_snooper   = sn_st == SLOT_BUSY;
	assign ready_for_cpu       = cpu_st == SLOT_BUSY;
	assign ready_for_forwarder = fwd_st == SLOT_BUSY;

endmodule

//--- hdl/packet_ram.sv
module packet_ram import packetmem_pkg::*; (
	input  logic     clk,
	input  mem_req_t req,
	input  logic     len_rst,	// Drops the packet length to zero
	output mem_rsp_t rsp
);

	// Even words in one bank, odd words in the other, so a pair
	// starting at any word comes out in a single cycle
	word_t even_mem [2**(WORD_ADDR_W-1)];
	word_t odd_mem  [2**(WORD_ADDR_W-1)];

	logic [WORD_ADDR_W-2:0] row;	// Bank row of req.addr
	logic [WORD_ADDR_W-2:0] row_next;	// Next row, wraps at the top
	logic [WORD_ADDR_W-2:0] even_row;
	plen_t                  wr_end;	// Length implied by this write

	word_t even_q, odd_q;	// Registered bank outputs
	logic  swap_q;	// Pair started on an odd word
	plen_t len_q;

	assign row      = req.addr[WORD_ADDR_W-1:1];
	assign row_next = row + 1'b1;
	// Odd start takes its high word from the next even row
	assign even_row = req.addr[0] ? row_next : row;
	assign wr_end   = plen_t'(req.addr) + 1'b1;

	always_ff @(posedge clk) begin
		if (req.we) begin
			if (req.addr[0]) odd_mem[row] <= req.wdata;
			else             even_mem[row] <= req.wdata;
		end
		if (req.re) begin	// Old data on a read during write
			even_q <= even_mem[even_row];
			odd_q  <= odd_mem[row];
			swap_q <= req.addr[0];
		end
	end

	// Length grows with the highest word written
	always_ff @(posedge clk) begin
		if (len_rst)
			len_q <= '0;
		else if (req.we && wr_end > len_q)
			len_q <= wr_end;
	end

	assign rsp.rdata_lo = swap_q ? odd_q : even_q;
	assign rsp.rdata_hi = swap_q ? even_q : odd_q;
	assign rsp.len      = len_q;

endmodule

//--- hdl/packetmem_pkg.sv
package packetmem_pkg;

	// Buffer geometry
	localparam int WORD_ADDR_W = 6;	// 64 words per buffer
	localparam int BYTE_ADDR_W = 8;	// 256 bytes per buffer
	localparam int WORD_W      = 32;	// Snooper and forwarder word
	localparam int NUM_BUFS    = 3;	// Ping, pang, pung

	typedef logic [WORD_ADDR_W-1:0] word_addr_t;
	typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
	typedef logic [WORD_W-1:0]      word_t;
	typedef logic [WORD_ADDR_W:0]   plen_t;	// 0 to 64 words, one extra bit

	// 0 is no buffer, 1..3 name ping, pang, pung
	typedef logic [1:0] buf_sel_t;

	// 0 one byte, 1 two bytes, 2 or 3 four bytes
	typedef logic [1:0] xfer_sz_t;

	// Per-agent slot in the buffer controller
	typedef enum logic [1:0] {
		SLOT_EMPTY,	// No buffer held
		SLOT_BUSY,	// Agent owns its buffer, ready is high
		SLOT_DONE,	// Snooper finished, CPU slot still full
		SLOT_WAIT	// CPU accepted, forwarder slot still full
	} ctrl_state_t;

	// One agent's access to one buffer
	typedef struct packed {
		word_addr_t addr;
		word_t      wdata;
		logic       we;
		logic       re;
	} mem_req_t;

	// Word pair at addr and addr+1, plus packet length
	typedef struct packed {
		word_t rdata_lo;
		word_t rdata_hi;	// Wraps within the buffer
		plen_t len;
	} mem_rsp_t;

endpackage
